/* bench/program_input.hex */
// first line: program word count, retire entry count
// then program words from word address 0, then retire entries as rd and data, then final pc
1d 0d
00500093 // 00 addi x1, x0, 5
ffd00113 // 04 addi x2, x0, -3
002081b3 // 08 add  x3, x1, x2
40118233 // 0c sub  x4, x3, x1
001222b3 // 10 slt  x5, x4, x1
00127333 // 14 and  x6, x4, x1
0062e3b3 // 18 or   x7, x5, x6
0023c433 // 1c xor  x8, x7, x2
00708013 // 20 addi x0, x1, 7
00802423 // 24 sw   x8, 8(x0)
00802483 // 28 lw   x9, 8(x0)
00148533 // 2c add  x10, x9, x1
00250463 // 30 beq  x10, x2, +8
06300593 // 34 addi x11, x0, 99 (skipped)
ffffffff // 38 illegal
04d00613 // 3c addi x12, x0, 77 (skipped)
02a00693 // 40 handler: addi x13, x0, 42
00169663 // 44 bne  x13, x1, +12
00100713 // 48 addi x14, x0, 1 (skipped)
00200793 // 4c addi x15, x0, 2 (skipped)
00208463 // 50 beq  x1, x2, +8 (not taken)
00c0086f // 54 jal  x16, +12
00300893 // 58 addi x17, x0, 3 (skipped)
00400913 // 5c addi x18, x0, 4 (skipped)
00d809b3 // 60 add  x19, x16, x13
00000073 // 64 ecall
00000013 // 68 nop
00000013 // 6c nop
00000013 // 70 nop
// retire trace, rd then data
01 00000005
02 fffffffd
03 00000002
04 fffffffd
05 00000001
06 00000005
07 00000005
08 fffffff8
09 fffffff8
0a fffffffd
0d 0000002a
10 00000058
13 00000082
// final pc
00000074

/* verilog.f */
verilog/cpu_pkg.sv
verilog/fetch_stage.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/memory_stage.sv
verilog/cpu5stage.sv
bench/clock_gen.sv
bench/cpu5stage_assertions.sv
bench/cpu5stage_tb.sv

/* Makefile */
VERILATOR = verilator
TOP = cpu5stage_tb
FILELIST = verilog.f
OBJ_DIR = obj_dir
LINT_FLAGS = --lint-only --timing --assert --top-module $(TOP)
SIM_FLAGS = --binary --timing --assert -Wno-fatal --top-module $(TOP) --Mdir $(OBJ_DIR)
PASS_MSG = No errors

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* bench/cpu5stage_tb.sv */
`default_nettype none

module cpu5stage_tb;
	import cpu_pkg::*;

	localparam int stim_words = 128;
	localparam int halt_timeout = 2000;
	localparam int drain_cycles = 10;

	logic input_clk;
	logic rst;
	logic imem_we;
	word_t imem_addr;
	word_t imem_wdata;
	word_t pc;
	word_t cycles_consumed;
	logic halted;
	logic retire_valid;
	reg_idx_t retire_rd;
	word_t retire_data;

	word_t stim [stim_words];
	int prog_count;
	int trace_count;
	int trace_base;
	word_t final_pc;
	word_t halt_cycles;
	int retired;
	int errors;
	int cycles;

	clock_gen clk0 (
		.clk(input_clk)
	);

	cpu5stage dut0 (
		.input_clk(input_clk),
		.rst(rst),
		.imem_we(imem_we),
		.imem_addr(imem_addr),
		.imem_wdata(imem_wdata),
		.pc(pc),
		.cycles_consumed(cycles_consumed),
		.halted(halted),
		.retire_valid(retire_valid),
		.retire_rd(retire_rd),
		.retire_data(retire_data)
	);

	task automatic report_mismatch(input string name, input word_t expected,
			input word_t actual);
		errors++;
		$display("Mismatch %s: expected %h, actual %h", name, expected, actual);
	endtask

	// outputs settle after the rising edge, so the trace is sampled on the falling one
	always @(negedge input_clk) begin
		if (!rst && retire_valid) begin
			if (halted) begin
				errors++;
				$display("retire of x%0d seen after halt", retire_rd);
			end else if (retired >= trace_count) begin
				errors++;
				$display("retire of x%0d beyond the %0d expected entries", retire_rd,
					trace_count);
			end else begin
				if (word_t'(retire_rd) != stim[trace_base + 2 * retired]) begin
					report_mismatch($sformatf("retire %0d rd", retired),
						stim[trace_base + 2 * retired], word_t'(retire_rd));
				end
				if (retire_data != stim[trace_base + 2 * retired + 1]) begin
					report_mismatch($sformatf("retire %0d data", retired),
						stim[trace_base + 2 * retired + 1], retire_data);
				end
			end
			retired++;
		end
	end

	initial begin
		rst = 1'b1;
		imem_we = 1'b0;
		imem_addr = '0;
		imem_wdata = '0;
		errors = 0;
		retired = 0;
		cycles = 0;
		$readmemh("bench/program_input.hex", stim);
		prog_count = int'(stim[0]);
		trace_count = int'(stim[1]);
		trace_base = 2 + prog_count;
		final_pc = stim[trace_base + 2 * trace_count];

		// program words go in one per edge while rst is high
		for (int i = 0; i < prog_count; i++) begin
			@(posedge input_clk);
			imem_we <= 1'b1;
			imem_addr <= word_t'(i);
			imem_wdata <= stim[2 + i];
		end
		@(posedge input_clk);
		imem_we <= 1'b0;
		repeat (5) @(posedge input_clk);
		rst <= 1'b0;

		while (!halted && cycles < halt_timeout) begin
			@(negedge input_clk);
			cycles++;
		end

		if (!halted) begin
			errors++;
			$display("timeout: halted did not rise within %0d cycles", halt_timeout);
		end else begin
			// the first falling edge after reset comes before any counted rising edge
			if (cycles_consumed != word_t'(cycles - 1)) begin
				report_mismatch("cycles consumed", word_t'(cycles - 1), cycles_consumed);
			end
			halt_cycles = cycles_consumed;
			repeat (drain_cycles) @(negedge input_clk);
			if (!halted) begin
				errors++;
				$display("halted fell while rst was low");
			end
			if (cycles_consumed != halt_cycles) begin
				report_mismatch("cycles after halt", halt_cycles, cycles_consumed);
			end
			if (pc != final_pc) begin
				report_mismatch("final pc", final_pc, pc);
			end
		end

		if (retired != trace_count) begin
			report_mismatch("retire count", word_t'(trace_count), word_t'(retired));
		end

		$display("retired %0d of %0d entries, error count %0d", retired, trace_count,
			errors);
		if (errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* bench/cpu5stage_assertions.sv */
`default_nettype none

module cpu5stage_assertions (
	input wire input_clk,
	input wire rst,
	input wire halted,
	input wire retire_valid,
	input wire cpu_pkg::reg_idx_t retire_rd,
	input wire cpu_pkg::word_t cycles_consumed
);

	retire_rd_nonzero: assert property (@(posedge input_clk) disable iff (rst)
		retire_valid |-> retire_rd != '0)
		else $error("retire pulse with rd of zero");

	// the counter must hold its value for as long as the core is halted
	cycles_frozen: assert property (@(posedge input_clk) disable iff (rst)
		halted |=> $stable(cycles_consumed))
		else $error("cycles_consumed changed while halted");

	no_retire_halted: assert property (@(posedge input_clk) disable iff (rst)
		halted |-> !retire_valid)
		else $error("retire pulse while halted");

	halted_sticky: assert property (@(posedge input_clk) disable iff (rst)
		halted |=> halted)
		else $error("halted fell without reset");

endmodule

bind cpu5stage cpu5stage_assertions asrt0 (
	.input_clk(input_clk),
	.rst(rst),
	.halted(halted),
	.retire_valid(retire_valid),
	.retire_rd(retire_rd),
	.cycles_consumed(cycles_consumed)
);

`default_nettype wire

/* bench/clock_gen.sv */
`default_nettype none

module clock_gen #(
	parameter int half_period = 10
) (
	output logic clk
);

	initial begin
		clk = 1'b0;
	end

	always begin
		#half_period clk = ~clk;
	end

endmodule

`default_nettype wire

/* verilog/cpu5stage.sv */
`default_nettype none

module cpu5stage #(
	parameter cpu_pkg::word_t handler_addr = 32'd64,
	parameter int imem_depth = 256,
	parameter int dmem_depth = 256
) (
	input wire input_clk,
	input wire rst,
	input wire imem_we,
	input wire cpu_pkg::word_t imem_addr,
	input wire cpu_pkg::word_t imem_wdata,
	output cpu_pkg::word_t pc,
	output cpu_pkg::word_t cycles_consumed,
	output logic halted,
	output logic retire_valid,
	output cpu_pkg::reg_idx_t retire_rd,
	output cpu_pkg::word_t retire_data
);
	import cpu_pkg::*;

	if_id_t if_id;
	id_ex_t id_ex;
	ex_mem_t ex_mem;
	mem_wb_t mem_wb;
	redirect_t ex_redirect;
	redirect_t id_redirect;
	logic stall;
	logic freeze;

	fetch_stage #(
		.handler_addr(handler_addr),
		.imem_depth(imem_depth)
	) fetch0 (
		.input_clk(input_clk),
		.rst(rst),
		.freeze(freeze),
		.stall(stall),
		.ex_redirect(ex_redirect),
		.id_redirect(id_redirect),
		.imem_we(imem_we),
		.imem_addr(imem_addr),
		.imem_wdata(imem_wdata),
		.pc(pc),
		.if_id(if_id)
	);

	decode_stage #(
		.handler_addr(handler_addr)
	) decode0 (
		.input_clk(input_clk),
		.rst(rst),
		.freeze(freeze),
		.if_id(if_id),
		.id_ex_fb(id_ex),
		.ex_redirect(ex_redirect),
		.mem_wb(mem_wb),
		.stall(stall),
		.id_redirect(id_redirect),
		.id_ex(id_ex)
	);

	execute_stage execute0 (
		.input_clk(input_clk),
		.rst(rst),
		.freeze(freeze),
		.id_ex(id_ex),
		.mem_wb(mem_wb),
		.ex_redirect(ex_redirect),
		.ex_mem(ex_mem)
	);

	memory_stage #(
		.dmem_depth(dmem_depth)
	) memory0 (
		.input_clk(input_clk),
		.rst(rst),
		.freeze(freeze),
		.ex_mem(ex_mem),
		.mem_wb(mem_wb)
	);

	// the halt entry stays in mem_wb once frozen, which keeps halted high
	assign freeze = mem_wb.valid && mem_wb.is_halt;
	assign halted = freeze;

	always_ff @(posedge input_clk) begin
		if (rst) begin
			cycles_consumed <= '0;
		end else if (!freeze) begin
			cycles_consumed <= cycles_consumed + 32'd1;
		end
	end

	assign retire_valid = mem_wb.valid && mem_wb.reg_write && mem_wb.rd != '0;
	assign retire_rd = mem_wb.rd;
	assign retire_data = mem_wb.wb_data;

endmodule

`default_nettype wire

/* verilog/memory_stage.sv */
`default_nettype none

module memory_stage #(
	parameter int dmem_depth = 256
) (
	input wire input_clk,
	input wire rst,
	input wire freeze,
	input wire cpu_pkg::ex_mem_t ex_mem,
	output cpu_pkg::mem_wb_t mem_wb
);
	import cpu_pkg::*;

	localparam int daw = $clog2(dmem_depth);

	word_t dmem [dmem_depth];
	logic [daw-1:0] daddr;
	word_t load_data;

	initial begin
		for (int i = 0; i < dmem_depth; i++) begin
			dmem[i] = '0;
		end
	end

	assign daddr = ex_mem.alu_result[daw+1:2];
	assign load_data = dmem[daddr];

	// stores behind a halt must not land once the pipeline is frozen
	always_ff @(posedge input_clk) begin
		if (!freeze && ex_mem.valid && ex_mem.mem_write) begin
			dmem[daddr] <= ex_mem.store_data;
		end
	end

	always_ff @(posedge input_clk) begin
		if (rst) begin
			mem_wb.valid <= 1'b0;
		end else if (!freeze) begin
			mem_wb.valid <= ex_mem.valid;
			mem_wb.rd <= ex_mem.rd;
			mem_wb.wb_data <= ex_mem.mem_read ? load_data : ex_mem.alu_result;
			mem_wb.reg_write <= ex_mem.reg_write;
			mem_wb.is_halt <= ex_mem.is_halt;
		end
	end

endmodule

`default_nettype wire

/* verilog/execute_stage.sv */
`default_nettype none

module execute_stage (
	input wire input_clk,
	input wire rst,
	input wire freeze,
	input wire cpu_pkg::id_ex_t id_ex,
	input wire cpu_pkg::mem_wb_t mem_wb,
	output cpu_pkg::redirect_t ex_redirect,
	output cpu_pkg::ex_mem_t ex_mem
);
	import cpu_pkg::*;

	word_t op_a;
	word_t op_b;
	word_t rs2_fwd;
	word_t alu_out;
	word_t link_addr;
	logic equal;
	ex_mem_t ex_next;

	// ex_mem is younger than mem_wb, so it is checked first
	function automatic word_t forward(reg_idx_t idx, word_t rf_val, ex_mem_t em,
			mem_wb_t wb);
		if (idx == '0) begin
			return rf_val;
		end
		if (em.valid && em.reg_write && !em.mem_read && em.rd == idx) begin
			return em.alu_result;
		end
		if (wb.valid && wb.reg_write && wb.rd == idx) begin
			return wb.wb_data;
		end
		return rf_val;
	endfunction

	assign op_a = forward(id_ex.rs1, id_ex.rs1_val, ex_mem, mem_wb);
	assign rs2_fwd = forward(id_ex.rs2, id_ex.rs2_val, ex_mem, mem_wb);
	assign op_b = id_ex.use_imm ? id_ex.imm : rs2_fwd;

	always_comb begin
		case (id_ex.alu_op)
			alu_add: alu_out = op_a + op_b;
			alu_sub: alu_out = op_a - op_b;
			alu_and: alu_out = op_a & op_b;
			alu_or: alu_out = op_a | op_b;
			alu_xor: alu_out = op_a ^ op_b;
			alu_slt: alu_out = {31'd0, $signed(op_a) < $signed(op_b)};
			default: alu_out = '0;
		endcase
	end

	assign equal = (op_a == rs2_fwd);
	assign link_addr = id_ex.pc + 32'd4;

	assign ex_redirect.taken = id_ex.valid &&
		((id_ex.is_beq && equal) || (id_ex.is_bne && !equal) || id_ex.is_jal);
	assign ex_redirect.target = id_ex.pc + id_ex.imm;

	always_comb begin
		ex_next.valid = id_ex.valid;
		ex_next.alu_result = id_ex.is_jal ? link_addr : alu_out;
		ex_next.store_data = rs2_fwd;
		ex_next.rd = id_ex.rd;
		ex_next.mem_read = id_ex.mem_read;
		ex_next.mem_write = id_ex.mem_write;
		ex_next.reg_write = id_ex.reg_write;
		ex_next.is_halt = id_ex.is_halt;
	end

	always_ff @(posedge input_clk) begin
		if (rst) begin
			ex_mem.valid <= 1'b0;
		end else if (!freeze) begin
			ex_mem <= ex_next;
		end
	end

endmodule

`default_nettype wire

/* verilog/decode_stage.sv */
`default_nettype none

module decode_stage #(
	parameter cpu_pkg::word_t handler_addr = 32'd64
) (
	input wire input_clk,
	input wire rst,
	input wire freeze,
	input wire cpu_pkg::if_id_t if_id,
	input wire cpu_pkg::id_ex_t id_ex_fb,
	input wire cpu_pkg::redirect_t ex_redirect,
	input wire cpu_pkg::mem_wb_t mem_wb,
	output logic stall,
	output cpu_pkg::redirect_t id_redirect,
	output cpu_pkg::id_ex_t id_ex
);
	import cpu_pkg::*;

	word_t regs [32];
	opcode_t opc;
	logic [2:0] funct3;
	reg_idx_t rs1;
	reg_idx_t rs2;
	logic illegal;
	logic uses_rs1;
	logic uses_rs2;
	logic load_use;
	id_ex_t id_next;

	function automatic word_t rf_read(reg_idx_t idx, word_t stored, mem_wb_t wb);
		if (idx == '0) begin
			return '0;
		end
		if (wb.valid && wb.reg_write && wb.rd == idx) begin
			return wb.wb_data;
		end
		return stored;
	endfunction

	always_ff @(posedge input_clk) begin
		if (mem_wb.valid && mem_wb.reg_write && mem_wb.rd != '0) begin
			regs[mem_wb.rd] <= mem_wb.wb_data;
		end
	end

	assign opc = opcode_t'(if_id.instr[6:0]);
	assign funct3 = if_id.instr[14:12];
	assign rs1 = if_id.instr[19:15];
	assign rs2 = if_id.instr[24:20];

	always_comb begin
		id_next = '0;
		id_next.pc = if_id.pc;
		id_next.rs1 = rs1;
		id_next.rs2 = rs2;
		id_next.rd = if_id.instr[11:7];
		id_next.rs1_val = rf_read(rs1, regs[rs1], mem_wb);
		id_next.rs2_val = rf_read(rs2, regs[rs2], mem_wb);
		id_next.alu_op = alu_add;
		illegal = 1'b0;
		uses_rs1 = 1'b0;
		uses_rs2 = 1'b0;
		case (opc)
			op_r: begin
				uses_rs1 = 1'b1;
				uses_rs2 = 1'b1;
				id_next.reg_write = 1'b1;
				case (funct3)
					3'b000: id_next.alu_op = if_id.instr[30] ? alu_sub : alu_add;
					3'b010: id_next.alu_op = alu_slt;
					3'b100: id_next.alu_op = alu_xor;
					3'b110: id_next.alu_op = alu_or;
					3'b111: id_next.alu_op = alu_and;
					default: id_next.alu_op = alu_add;
				endcase
			end
			op_imm, op_load: begin
				uses_rs1 = 1'b1;
				id_next.imm = {{20{if_id.instr[31]}}, if_id.instr[31:20]};
				id_next.use_imm = 1'b1;
				id_next.reg_write = 1'b1;
				id_next.mem_read = (opc == op_load);
			end
			op_store: begin
				uses_rs1 = 1'b1;
				uses_rs2 = 1'b1;
				id_next.imm = {{20{if_id.instr[31]}}, if_id.instr[31:25],
					if_id.instr[11:7]};
				id_next.use_imm = 1'b1;
				id_next.mem_write = 1'b1;
			end
			op_branch: begin
				uses_rs1 = 1'b1;
				uses_rs2 = 1'b1;
				id_next.imm = {{19{if_id.instr[31]}}, if_id.instr[31], if_id.instr[7],
					if_id.instr[30:25], if_id.instr[11:8], 1'b0};
				id_next.is_beq = (funct3 == 3'b000);
				id_next.is_bne = (funct3 == 3'b001);
			end
			op_jal: begin
				id_next.imm = {{11{if_id.instr[31]}}, if_id.instr[31], if_id.instr[19:12],
					if_id.instr[20], if_id.instr[30:21], 1'b0};
				id_next.reg_write = 1'b1;
				id_next.is_jal = 1'b1;
			end
			op_system: id_next.is_halt = 1'b1;
			default: illegal = 1'b1;
		endcase
		id_next.valid = if_id.valid && !illegal && !stall && !ex_redirect.taken;
	end

	// a load still in execute cannot forward, so the consumer waits one cycle
	assign load_use = id_ex_fb.valid && id_ex_fb.mem_read && id_ex_fb.rd != '0 &&
		((uses_rs1 && rs1 == id_ex_fb.rd) || (uses_rs2 && rs2 == id_ex_fb.rd));
	assign stall = if_id.valid && load_use && !ex_redirect.taken;

	assign id_redirect.taken = if_id.valid && illegal && !ex_redirect.taken;
	assign id_redirect.target = handler_addr;

	always_ff @(posedge input_clk) begin
		if (rst) begin
			id_ex.valid <= 1'b0;
		end else if (!freeze) begin
			id_ex <= id_next;
		end
	end

endmodule

`default_nettype wire

/* verilog/fetch_stage.sv */
`default_nettype none

module fetch_stage #(
	parameter cpu_pkg::word_t handler_addr = 32'd64,
	parameter int imem_depth = 256
) (
	input wire input_clk,
	input wire rst,
	input wire freeze,
	input wire stall,
	input wire cpu_pkg::redirect_t ex_redirect,
	input wire cpu_pkg::redirect_t id_redirect,
	input wire imem_we,
	input wire cpu_pkg::word_t imem_addr,
	input wire cpu_pkg::word_t imem_wdata,
	output cpu_pkg::word_t pc,
	output cpu_pkg::if_id_t if_id
);
	import cpu_pkg::*;

	localparam int iaw = $clog2(imem_depth);

	word_t imem [imem_depth];

	// the load port takes a word index, the pc is a byte address
	always_ff @(posedge input_clk) begin
		if (rst && imem_we) begin
			imem[imem_addr[iaw-1:0]] <= imem_wdata;
		end
	end

	always_ff @(posedge input_clk) begin
		if (rst) begin
			pc <= '0;
			if_id.valid <= 1'b0;
		end else if (!freeze) begin
			if (ex_redirect.taken) begin
				pc <= ex_redirect.target;
				if_id.valid <= 1'b0;
			end else if (id_redirect.taken) begin
				pc <= handler_addr;
				if_id.valid <= 1'b0;
			end else if (!stall) begin
				pc <= pc + 32'd4;
				if_id <= '{valid: 1'b1, pc: pc, instr: imem[pc[iaw+1:2]]};
			end
		end
	end

endmodule

`default_nettype wire

/* verilog/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0] reg_idx_t;

	// major opcodes of the supported RV32I subset
	typedef enum logic [6:0] {
		op_r      = 7'b0110011,
		op_imm    = 7'b0010011,
		op_load   = 7'b0000011,
		op_store  = 7'b0100011,
		op_branch = 7'b1100011,
		op_jal    = 7'b1101111,
		op_system = 7'b1110011
	} opcode_t;

	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_slt
	} alu_op_t;

	typedef struct packed {
		logic valid;
		word_t pc;
		word_t instr;
	} if_id_t;

	typedef struct packed {
		logic valid;
		word_t pc;
		word_t rs1_val;
		word_t rs2_val;
		reg_idx_t rs1;
		reg_idx_t rs2;
		reg_idx_t rd;
		word_t imm;
		alu_op_t alu_op;
		logic use_imm;
		logic mem_read;
		logic mem_write;
		logic reg_write;
		logic is_beq;
		logic is_bne;
		logic is_jal;
		logic is_halt;
	} id_ex_t;

	typedef struct packed {
		logic valid;
		word_t alu_result;
		word_t store_data;
		reg_idx_t rd;
		logic mem_read;
		logic mem_write;
		logic reg_write;
		logic is_halt;
	} ex_mem_t;

	typedef struct packed {
		logic valid;
		reg_idx_t rd;
		word_t wb_data;
		logic reg_write;
		logic is_halt;
	} mem_wb_t;

	typedef struct packed {
		logic taken;
		word_t target;
	} redirect_t;

endpackage

`default_nettype wire
